// ==== compile.f ====
+incdir+tests
logic/core_mem_pkg.sv
logic/lsu_addr_decode.sv
logic/ram_port_arbiter.sv
logic/data_ram.sv
logic/core_mem_region.sv
tests/tb_core_mem_region.sv

// ==== Bender.yml ====
package:
  name: core_mem_region

sources:
  - logic/core_mem_pkg.sv
  - logic/lsu_addr_decode.sv
  - logic/ram_port_arbiter.sv
  - logic/data_ram.sv
  - logic/core_mem_region.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_core_mem_region.sv

// ==== tests/mem_region_vectors.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory region test vectors
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef MEM_REGION_VECTORS_SVH
`define MEM_REGION_VECTORS_SVH

// request port(s) a vector drives
typedef enum logic [1:0] {
  PORT_LSU,
  PORT_LDR,
  PORT_BOTH
} port_e;

// one row: port, payloads, expected LSU data, expected loader data, external flag
typedef struct packed {
  port_e                  port;
  core_mem_pkg::lsu_req_t lsu_pl;
  core_mem_pkg::ram_req_t ldr_pl;
  logic [31:0]            exp_lsu;
  logic [63:0]            exp_ldr;
  logic                   exp_ext;
} vec_t;

// local region base is 0x0010_0000
task automatic load_vectors();
  // loader fills full words, LSU reads back each lane
  add_vector("ldr_wr0", PORT_LDR, '0,
             make_ram_req(16'd0, 1'b1, 8'hff, 64'h1122_3344_5566_7788), 32'h0, 64'h0, 1'b0);
  add_vector("lsu_rd_lo", PORT_LSU, make_lsu_req(32'h0010_0000, 1'b0, 4'hf, 32'h0), '0,
             32'h5566_7788, 64'h0, 1'b0);
  add_vector("lsu_rd_hi", PORT_LSU, make_lsu_req(32'h0010_0004, 1'b0, 4'hf, 32'h0), '0,
             32'h1122_3344, 64'h0, 1'b0);
  add_vector("ldr_wr5", PORT_LDR, '0,
             make_ram_req(16'd5, 1'b1, 8'hff, 64'hdead_beef_cafe_f00d), 32'h0, 64'h0, 1'b0);
  add_vector("lsu_rd5_hi", PORT_LSU, make_lsu_req(32'h0010_002c, 1'b0, 4'hf, 32'h0), '0,
             32'hdead_beef, 64'h0, 1'b0);

  // byte-enabled LSU writes, checked through the loader
  add_vector("lsu_wr_be_hi", PORT_LSU, make_lsu_req(32'h0010_0004, 1'b1, 4'b0101, 32'haabb_ccdd),
             '0, 32'h0, 64'h0, 1'b0);
  add_vector("ldr_rd0", PORT_LDR, '0, make_ram_req(16'd0, 1'b0, 8'h00, 64'h0),
             32'h0, 64'h11bb_33dd_5566_7788, 1'b0);
  add_vector("lsu_wr_be_lo", PORT_LSU, make_lsu_req(32'h0010_0028, 1'b1, 4'b1000, 32'h0102_0304),
             '0, 32'h0, 64'h0, 1'b0);
  add_vector("ldr_rd5", PORT_LDR, '0, make_ram_req(16'd5, 1'b0, 8'h00, 64'h0),
             32'h0, 64'hdead_beef_01fe_f00d, 1'b0);

  // outside the local region, answered with address ^ 0x5a5a_0000
  add_vector("ext_rd", PORT_LSU, make_lsu_req(32'h2000_0010, 1'b0, 4'hf, 32'h0), '0,
             32'h7a5a_0010, 64'h0, 1'b1);
  add_vector("ext_wr", PORT_LSU, make_lsu_req(32'h0020_0100, 1'b1, 4'h3, 32'h1234_5678), '0,
             32'h5a7a_0100, 64'h0, 1'b1);
  add_vector("lsu_rd_after_ext", PORT_LSU, make_lsu_req(32'h0010_0004, 1'b0, 4'hf, 32'h0), '0,
             32'h11bb_33dd, 64'h0, 1'b0);
  add_vector("ext_rd_top", PORT_LSU, make_lsu_req(32'hfff0_0008, 1'b0, 4'hf, 32'h0), '0,
             32'ha5aa_0008, 64'h0, 1'b1);

  // loader and LSU in the same cycle
  add_vector("both_rd", PORT_BOTH, make_lsu_req(32'h0010_0000, 1'b0, 4'hf, 32'h0),
             make_ram_req(16'd5, 1'b0, 8'h00, 64'h0),
             32'h5566_7788, 64'hdead_beef_01fe_f00d, 1'b0);
  add_vector("both_ldr_wr", PORT_BOTH, make_lsu_req(32'h0010_003c, 1'b0, 4'hf, 32'h0),
             make_ram_req(16'd7, 1'b1, 8'hff, 64'h0f0e_0d0c_0b0a_0908),
             32'h0f0e_0d0c, 64'h0, 1'b0);
  add_vector("lsu_rd7_lo", PORT_LSU, make_lsu_req(32'h0010_0038, 1'b0, 4'hf, 32'h0), '0,
             32'h0b0a_0908, 64'h0, 1'b0);
endtask

`endif

// ==== tests/tb_core_mem_region.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data memory region testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module tb_core_mem_region;

  localparam int unsigned MaxWait = 10;

  `include "mem_region_vectors.svh"

  logic                                   clk;
  logic                                   rst_n;
  logic                                   lsu_req_i;
  core_mem_pkg::lsu_req_t                 lsu_pl_i;
  logic                                   lsu_gnt_o;
  logic                                   lsu_rvalid_o;
  logic [core_mem_pkg::CoreDataWidth-1:0] lsu_rdata_o;
  logic                                   ldr_req_i;
  core_mem_pkg::ram_req_t                 ldr_pl_i;
  logic [core_mem_pkg::RamDataWidth-1:0]  ldr_rdata_o;
  logic                                   ext_req_o;
  core_mem_pkg::lsu_req_t                 ext_pl_o;
  logic                                   ext_gnt_i;
  logic                                   ext_rvalid_i;
  logic [core_mem_pkg::CoreDataWidth-1:0] ext_rdata_i;

  string                  vec_name [$];
  vec_t                   vec_tab  [$];
  core_mem_pkg::lsu_req_t ext_log  [$];
  logic [31:0]            rand_state;
  int unsigned            error_count;
  int unsigned            check_count;
  int unsigned            tests_failed;
  int unsigned            cycle_count;
  int unsigned            timeout_cycles;

  core_mem_region u_core_mem_region (
    .clk          ( clk          ),
    .rst_n        ( rst_n        ),
    .lsu_req_i    ( lsu_req_i    ),
    .lsu_pl_i     ( lsu_pl_i     ),
    .lsu_gnt_o    ( lsu_gnt_o    ),
    .lsu_rvalid_o ( lsu_rvalid_o ),
    .lsu_rdata_o  ( lsu_rdata_o  ),
    .ldr_req_i    ( ldr_req_i    ),
    .ldr_pl_i     ( ldr_pl_i     ),
    .ldr_rdata_o  ( ldr_rdata_o  ),
    .ext_req_o    ( ext_req_o    ),
    .ext_pl_o     ( ext_pl_o     ),
    .ext_gnt_i    ( ext_gnt_i    ),
    .ext_rvalid_i ( ext_rvalid_i ),
    .ext_rdata_i  ( ext_rdata_i  )
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic core_mem_pkg::lsu_req_t make_lsu_req(input logic [31:0] addr,
      input logic we, input logic [3:0] be, input logic [31:0] wdata);
    core_mem_pkg::lsu_req_t req;
    req.addr  = addr;
    req.we    = we;
    req.be    = be;
    req.wdata = wdata;
    return req;
  endfunction

  function automatic core_mem_pkg::ram_req_t make_ram_req(input logic [15:0] idx,
      input logic we, input logic [7:0] be, input logic [63:0] wdata);
    core_mem_pkg::ram_req_t req;
    req.idx   = idx;
    req.we    = we;
    req.be    = be;
    req.wdata = wdata;
    return req;
  endfunction

  function automatic void add_vector(input string name, input port_e port,
      input core_mem_pkg::lsu_req_t lsu_pl, input core_mem_pkg::ram_req_t ldr_pl,
      input logic [31:0] exp_lsu, input logic [63:0] exp_ldr, input logic exp_ext);
    vec_t v;
    v.port    = port;
    v.lsu_pl  = lsu_pl;
    v.ldr_pl  = ldr_pl;
    v.exp_lsu = exp_lsu;
    v.exp_ldr = exp_ldr;
    v.exp_ext = exp_ext;
    vec_name.push_back(name);
    vec_tab.push_back(v);
  endfunction

  task automatic check_value(input string what, input logic [127:0] expected,
      input logic [127:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("MISMATCH %s: expected %0h, actual %0h", what, expected, actual);
    end
  endtask

  task automatic report_failure(input string what);
    error_count++;
    $display("ERROR %s", what);
  endtask

  task automatic report_test(input string name, input int unsigned errs_before);
    if (error_count == errs_before) begin
      $display("test %s ok", name);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", name, error_count - errs_before);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // polls grant or rvalid at mid-cycle, counting the cycles waited
  task automatic wait_lsu_event(input bit want_rvalid, output int unsigned waited,
      output bit ok);
    waited = 0;
    ok     = want_rvalid ? lsu_rvalid_o : lsu_gnt_o;
    while (!ok && waited < MaxWait) begin
      @(negedge clk);
      waited++;
      ok = want_rvalid ? lsu_rvalid_o : lsu_gnt_o;
    end
  endtask

  task automatic check_idle();
    int unsigned errs_before;
    errs_before = error_count;
    repeat (5) begin
      @(negedge clk);
      check_value("idle_after_reset/lsu_gnt_o", 0, lsu_gnt_o);
      check_value("idle_after_reset/lsu_rvalid_o", 0, lsu_rvalid_o);
      check_value("idle_after_reset/ext_req_o", 0, ext_req_o);
    end
    report_test("idle_after_reset", errs_before);
  endtask

  task automatic apply_vector(input int unsigned i);
    vec_t        v;
    string       name;
    bit          has_lsu;
    bit          has_ldr;
    bit          ok;
    int unsigned waited;
    int unsigned errs_before;
    int unsigned log_before;
    v           = vec_tab[i];
    name        = vec_name[i];
    errs_before = error_count;
    log_before  = ext_log.size();
    has_lsu     = (v.port != PORT_LDR);
    has_ldr     = (v.port != PORT_LSU);

    next_cycle();
    if (has_ldr) begin
      ldr_req_i = 1'b1;
      ldr_pl_i  = v.ldr_pl;
    end
    if (has_lsu) begin
      lsu_req_i = 1'b1;
      lsu_pl_i  = v.lsu_pl;
    end
    @(negedge clk);

    // loader is served at once, the LSU waits behind it
    if (has_ldr) begin
      if (has_lsu) begin
        check_value({name, "/lsu_gnt_o"}, 0, lsu_gnt_o);
      end
      next_cycle();
      ldr_req_i = 1'b0;
      ldr_pl_i  = '0;
      @(negedge clk);
      if (!v.ldr_pl.we) begin
        check_value({name, "/ldr_rdata_o"}, v.exp_ldr, ldr_rdata_o);
      end
    end

    if (has_lsu) begin
      wait_lsu_event(1'b0, waited, ok);
      next_cycle();
      lsu_req_i = 1'b0;
      lsu_pl_i  = '0;
      if (!ok) begin
        report_failure({name, ": no grant on the LSU port within 10 cycles"});
      end else begin
        // local grant lands in the first cycle without a loader request
        if (!v.exp_ext) begin
          check_value({name, "/grant delay"}, 0, waited);
        end
        @(negedge clk);
        wait_lsu_event(1'b1, waited, ok);
        if (!ok) begin
          report_failure({name, ": no LSU response within 10 cycles of the grant"});
        end else begin
          if (!v.exp_ext) begin
            check_value({name, "/rvalid delay"}, 0, waited);
          end
          if (!v.lsu_pl.we || v.exp_ext) begin
            check_value({name, "/lsu_rdata_o"}, v.exp_lsu, lsu_rdata_o);
          end
        end
      end
      if (v.exp_ext) begin
        check_value({name, "/ext request count"}, log_before + 1, ext_log.size());
        if (ext_log.size() > log_before) begin
          check_value({name, "/ext_pl_o"}, v.lsu_pl, ext_log[log_before]);
        end
      end else begin
        check_value({name, "/ext request count"}, log_before, ext_log.size());
      end
    end
    report_test(name, errs_before);
  endtask

  // external bus: grant after 0 to 3 cycles, response one cycle after grant
  initial begin : ext_bus
    core_mem_pkg::lsu_req_t req;
    int unsigned            delay;
    ext_gnt_i    = 1'b0;
    ext_rvalid_i = 1'b0;
    ext_rdata_i  = '0;
    rand_state   = 32'ha6634312;
    forever begin
      @(negedge clk);
      if (rst_n && ext_req_o) begin
        req        = ext_pl_o;
        rand_state = lcg_next(rand_state);
        delay      = rand_state[17:16];
        ext_log.push_back(req);
        $display("ext bus request: addr %h we %b be %h wdata %h, grant in %0d cycles",
                 req.addr, req.we, req.be, req.wdata, delay);
        repeat (delay) @(posedge clk);
        next_cycle();
        ext_gnt_i = 1'b1;
        next_cycle();
        ext_gnt_i    = 1'b0;
        ext_rvalid_i = 1'b1;
        ext_rdata_i  = req.addr ^ 32'h5a5a_0000;
        next_cycle();
        ext_rvalid_i = 1'b0;
        ext_rdata_i  = '0;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout: run stopped after %0d cycles", cycle_count);
      $display(">>> FAIL");
      $finish;
    end
  end

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    lsu_req_i    = 1'b0;
    lsu_pl_i     = '0;
    ldr_req_i    = 1'b0;
    ldr_pl_i     = '0;
    error_count  = 0;
    check_count  = 0;
    tests_failed = 0;
    cycle_count  = 0;
    load_vectors();
    timeout_cycles = vec_tab.size() * 20 + 100;

    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;

    check_idle();
    for (int i = 0; i < vec_tab.size(); i++) begin
      apply_vector(i);
    end

    $display("tests %0d, passed %0d, failed %0d, checks %0d, errors %0d",
             vec_tab.size() + 1, vec_tab.size() + 1 - tests_failed, tests_failed,
             check_count, error_count);
    if (error_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== logic/core_mem_region.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Core data memory region
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module core_mem_region #(
  parameter int unsigned RAM_SIZE     = 32768,
  parameter logic [11:0] LOCAL_REGION = core_mem_pkg::DefaultLocalRegion
) (
  input  logic                                   clk,
  input  logic                                   rst_n,

  // load/store unit
  input  logic                                   lsu_req_i,
  input  core_mem_pkg::lsu_req_t                 lsu_pl_i,
  output logic                                   lsu_gnt_o,
  output logic                                   lsu_rvalid_o,
  output logic [core_mem_pkg::CoreDataWidth-1:0] lsu_rdata_o,

  // wide loader
  input  logic                                   ldr_req_i,
  input  core_mem_pkg::ram_req_t                 ldr_pl_i,
  output logic [core_mem_pkg::RamDataWidth-1:0]  ldr_rdata_o,

  // external bus
  output logic                                   ext_req_o,
  output core_mem_pkg::lsu_req_t                 ext_pl_o,
  input  logic                                   ext_gnt_i,
  input  logic                                   ext_rvalid_i,
  input  logic [core_mem_pkg::CoreDataWidth-1:0] ext_rdata_i
);

  // decode to arbiter
  logic                                   ram_lsu_req;
  core_mem_pkg::lsu_req_t                 ram_lsu_pl;
  logic                                   ram_lsu_gnt;
  logic                                   ram_lsu_rvalid;
  logic [core_mem_pkg::CoreDataWidth-1:0] ram_lsu_rdata;

  // arbiter to RAM
  logic                                   ram_en;
  core_mem_pkg::ram_req_t                 ram_pl;
  logic [core_mem_pkg::RamDataWidth-1:0]  ram_rdata;

  lsu_addr_decode #(
    .LOCAL_REGION ( LOCAL_REGION )
  ) u_lsu_addr_decode (
    .clk          ( clk            ),
    .rst_n        ( rst_n          ),
    .lsu_req_i    ( lsu_req_i      ),
    .lsu_pl_i     ( lsu_pl_i       ),
    .lsu_gnt_o    ( lsu_gnt_o      ),
    .lsu_rvalid_o ( lsu_rvalid_o   ),
    .lsu_rdata_o  ( lsu_rdata_o    ),
    .ram_req_o    ( ram_lsu_req    ),
    .ram_pl_o     ( ram_lsu_pl     ),
    .ram_gnt_i    ( ram_lsu_gnt    ),
    .ram_rvalid_i ( ram_lsu_rvalid ),
    .ram_rdata_i  ( ram_lsu_rdata  ),
    .ext_req_o    ( ext_req_o      ),
    .ext_pl_o     ( ext_pl_o       ),
    .ext_gnt_i    ( ext_gnt_i      ),
    .ext_rvalid_i ( ext_rvalid_i   ),
    .ext_rdata_i  ( ext_rdata_i    )
  );

  ram_port_arbiter #(
    .RAM_SIZE ( RAM_SIZE )
  ) u_ram_port_arbiter (
    .clk             ( clk            ),
    .rst_n           ( rst_n          ),
    .wide_req_i      ( ldr_req_i      ),
    .wide_pl_i       ( ldr_pl_i       ),
    .wide_rdata_o    ( ldr_rdata_o    ),
    .narrow_req_i    ( ram_lsu_req    ),
    .narrow_pl_i     ( ram_lsu_pl     ),
    .narrow_gnt_o    ( ram_lsu_gnt    ),
    .narrow_rvalid_o ( ram_lsu_rvalid ),
    .narrow_rdata_o  ( ram_lsu_rdata  ),
    .ram_en_o        ( ram_en         ),
    .ram_pl_o        ( ram_pl         ),
    .ram_rdata_i     ( ram_rdata      )
  );

  data_ram #(
    .RAM_SIZE ( RAM_SIZE )
  ) u_data_ram (
    .clk         ( clk       ),
    .ram_en_i    ( ram_en    ),
    .ram_pl_i    ( ram_pl    ),
    .ram_rdata_o ( ram_rdata )
  );

endmodule

// ==== logic/data_ram.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data RAM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module data_ram #(
  parameter int unsigned RAM_SIZE = 32768
) (
  input  logic                                  clk,
  input  logic                                  ram_en_i,
  input  core_mem_pkg::ram_req_t                ram_pl_i,
  output logic [core_mem_pkg::RamDataWidth-1:0] ram_rdata_o
);

  localparam int unsigned Words   = RAM_SIZE / 8;
  localparam int unsigned IdxBits = $clog2(Words);

  logic [core_mem_pkg::RamDataWidth-1:0] mem [Words];
  logic [IdxBits-1:0]                    word_idx;

  assign word_idx = ram_pl_i.idx[IdxBits-1:0];

  // byte-masked write, read of the addressed word
  always_ff @(posedge clk) begin
    if (ram_en_i) begin
      if (ram_pl_i.we) begin
        for (int b = 0; b < core_mem_pkg::RamBeWidth; b++) begin
          if (ram_pl_i.be[b]) begin
            mem[word_idx][b*8 +: 8] <= ram_pl_i.wdata[b*8 +: 8];
          end
        end
      end
      // old contents on a write cycle
      ram_rdata_o <= mem[word_idx];
    end
  end

  a_idx_in_range : assert property (
    @(posedge clk)
    ram_en_i |-> (ram_pl_i.idx < Words)
  );

endmodule

// ==== logic/ram_port_arbiter.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RAM port arbiter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module ram_port_arbiter #(
  parameter int unsigned RAM_SIZE = 32768
) (
  input  logic                                   clk,
  input  logic                                   rst_n,

  // wide loader port, always served
  input  logic                                   wide_req_i,
  input  core_mem_pkg::ram_req_t                 wide_pl_i,
  output logic [core_mem_pkg::RamDataWidth-1:0]  wide_rdata_o,

  // narrow LSU port, served when the loader is idle
  input  logic                                   narrow_req_i,
  input  core_mem_pkg::lsu_req_t                 narrow_pl_i,
  output logic                                   narrow_gnt_o,
  output logic                                   narrow_rvalid_o,
  output logic [core_mem_pkg::CoreDataWidth-1:0] narrow_rdata_o,

  // single RAM port
  output logic                                   ram_en_o,
  output core_mem_pkg::ram_req_t                 ram_pl_o,
  input  logic [core_mem_pkg::RamDataWidth-1:0]  ram_rdata_i
);

  // byte address bits that index a 64-bit word
  localparam int unsigned IdxBits = $clog2(RAM_SIZE) - 3;

  core_mem_pkg::ram_req_t narrow_pl;
  logic                   narrow_lane;
  logic                   narrow_rvalid_q;
  logic                   lane_q;

  // bit 2 picks the upper or lower half of the word
  assign narrow_lane = narrow_pl_i.addr[2];

  // widen the 32-bit request into a 64-bit RAM request
  always_comb begin
    narrow_pl                  = '0;
    narrow_pl.idx[IdxBits-1:0] = narrow_pl_i.addr[IdxBits+2:3];
    narrow_pl.we               = narrow_pl_i.we;
    if (narrow_lane) begin
      narrow_pl.be = {narrow_pl_i.be, {core_mem_pkg::CoreBeWidth{1'b0}}};
    end else begin
      narrow_pl.be = {{core_mem_pkg::CoreBeWidth{1'b0}}, narrow_pl_i.be};
    end
    // same data in both halves, the byte enables pick the lane
    narrow_pl.wdata = {narrow_pl_i.wdata, narrow_pl_i.wdata};
  end

  // fixed priority for the loader
  assign narrow_gnt_o = narrow_req_i & ~wide_req_i;
  assign ram_en_o     = wide_req_i | narrow_req_i;
  assign ram_pl_o     = wide_req_i ? wide_pl_i : narrow_pl;

  // remember the served port and lane for the response cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      narrow_rvalid_q <= 1'b0;
      lane_q          <= 1'b0;
    end else begin
      narrow_rvalid_q <= narrow_gnt_o;
      if (narrow_gnt_o) begin
        lane_q <= narrow_lane;
      end
    end
  end

  assign narrow_rvalid_o = narrow_rvalid_q;

  always_comb begin
    if (lane_q) begin
      narrow_rdata_o = ram_rdata_i[core_mem_pkg::RamDataWidth-1 -: core_mem_pkg::CoreDataWidth];
    end else begin
      narrow_rdata_o = ram_rdata_i[core_mem_pkg::CoreDataWidth-1:0];
    end
  end

  // loader takes the full word
  assign wide_rdata_o = ram_rdata_i;

endmodule

// ==== logic/lsu_addr_decode.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// LSU address decode
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module lsu_addr_decode #(
  parameter logic [11:0] LOCAL_REGION = core_mem_pkg::DefaultLocalRegion
) (
  input  logic                                   clk,
  input  logic                                   rst_n,

  // core side
  input  logic                                   lsu_req_i,
  input  core_mem_pkg::lsu_req_t                 lsu_pl_i,
  output logic                                   lsu_gnt_o,
  output logic                                   lsu_rvalid_o,
  output logic [core_mem_pkg::CoreDataWidth-1:0] lsu_rdata_o,

  // local RAM path
  output logic                                   ram_req_o,
  output core_mem_pkg::lsu_req_t                 ram_pl_o,
  input  logic                                   ram_gnt_i,
  input  logic                                   ram_rvalid_i,
  input  logic [core_mem_pkg::CoreDataWidth-1:0] ram_rdata_i,

  // external bus path
  output logic                                   ext_req_o,
  output core_mem_pkg::lsu_req_t                 ext_pl_o,
  input  logic                                   ext_gnt_i,
  input  logic                                   ext_rvalid_i,
  input  logic [core_mem_pkg::CoreDataWidth-1:0] ext_rdata_i
);

  typedef enum logic {
    SRC_RAM,
    SRC_EXT
  } resp_src_e;

  logic      is_local;
  resp_src_e resp_src_q;
  resp_src_e resp_src_d;

  // region match on the top 12 address bits
  assign is_local  = (lsu_pl_i.addr[core_mem_pkg::AddrWidth-1 -: 12] == LOCAL_REGION);

  assign ram_req_o = lsu_req_i & is_local;
  assign ext_req_o = lsu_req_i & ~is_local;

  // payload goes to both paths, only one of them sees a request
  assign ram_pl_o  = lsu_pl_i;
  assign ext_pl_o  = lsu_pl_i;

  // grant from the chosen path, remember where the answer comes from
  always_comb begin
    resp_src_d = resp_src_q;
    lsu_gnt_o  = 1'b0;
    if (ext_req_o) begin
      lsu_gnt_o = ext_gnt_i;
      if (ext_gnt_i) begin
        resp_src_d = SRC_EXT;
      end
    end else if (ram_req_o) begin
      lsu_gnt_o = ram_gnt_i;
      if (ram_gnt_i) begin
        resp_src_d = SRC_RAM;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_src_q <= SRC_RAM;
    end else begin
      resp_src_q <= resp_src_d;
    end
  end

  // route the response back to the core
  assign lsu_rdata_o  = (resp_src_q == SRC_EXT) ? ext_rdata_i : ram_rdata_i;
  assign lsu_rvalid_o = ram_rvalid_i | ext_rvalid_i;

  // core holds a request and its payload until granted
  a_req_held : assert property (
    @(posedge clk) disable iff (!rst_n)
    (lsu_req_i && !lsu_gnt_o) |=> (lsu_req_i && $stable(lsu_pl_i))
  );

  // responses are in order, so both paths never answer together
  a_one_path_rvalid : assert property (
    @(posedge clk) disable iff (!rst_n)
    !(ram_rvalid_i && ext_rvalid_i)
  );

endmodule

// ==== logic/core_mem_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data memory shared types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package core_mem_pkg;

  // load/store unit side
  parameter int unsigned CoreDataWidth = 32;
  parameter int unsigned CoreBeWidth   = CoreDataWidth / 8;
  parameter int unsigned AddrWidth     = 32;

  // RAM and loader side
  parameter int unsigned RamDataWidth  = 64;
  parameter int unsigned RamBeWidth    = RamDataWidth / 8;

  // word index into the RAM, bounds the RAM size
  parameter int unsigned RamIdxWidth   = 16;

  // upper 12 address bits that select the local RAM
  parameter logic [11:0] DefaultLocalRegion = 12'h001;

  // request as issued by the core, 69 bits
  typedef struct packed {
    logic [AddrWidth-1:0]     addr;
    logic                     we;
    logic [CoreBeWidth-1:0]   be;
    logic [CoreDataWidth-1:0] wdata;
  } lsu_req_t;

  // request as seen by the single-port RAM, 89 bits
  typedef struct packed {
    logic [RamIdxWidth-1:0]  idx;
    logic                    we;
    logic [RamBeWidth-1:0]   be;
    logic [RamDataWidth-1:0] wdata;
  } ram_req_t;

endpackage
